// ==== hdl/ptw_pkg.sv ====
package ptw_pkg;

    // ----------------------------------------
    // Sv32 address widths
    // ----------------------------------------

    // virtual address width
    localparam int unsigned VLEN = 32;
    // physical address width, 34 bits under Sv32
    localparam int unsigned PLEN = 34;
    // ppn width of satp and of a PTE
    localparam int unsigned PPNW = 22;
    // full virtual page number, vpn[1] and vpn[0] together
    localparam int unsigned VPNW = 20;
    // address space identifier width
    localparam int unsigned ASIDW = 9;

    // ----------------------------------------
    // PTE bit positions
    // ----------------------------------------

    // valid
    localparam int unsigned PTE_V = 0;
    // readable
    localparam int unsigned PTE_R = 1;
    // writable
    localparam int unsigned PTE_W = 2;
    // executable
    localparam int unsigned PTE_X = 3;
    // bit 4 is the user bit, the walker never looks at it
    // global mapping
    localparam int unsigned PTE_G = 5;
    // accessed, managed by software here
    localparam int unsigned PTE_A = 6;
    // dirty, also managed by software
    localparam int unsigned PTE_D = 7;

    // ----------------------------------------
    // PMP configuration
    // ----------------------------------------

    // number of pmp entries seen by the walker
    localparam int unsigned PMP_ENTRIES = 16;
    // pmpaddr holds physical address bits 33:2
    localparam int unsigned PMP_ADDRW = 32;

    // read permission inside one config byte
    localparam int unsigned PMP_R = 0;
    // two bit address matching mode starts here
    localparam int unsigned PMP_A_LSB = 3;

    // mode codes of the A field
    // na4 (2'b10) is not decoded and behaves like off
    localparam logic [1:0] PMP_OFF = 2'b00;
    localparam logic [1:0] PMP_TOR = 2'b01;
    localparam logic [1:0] PMP_NAPOT = 2'b11;

endpackage

// ==== hdl/pmp_region_match.sv ====
module pmp_region_match (
    // pointer of the page-table read being checked
    input  logic [ptw_pkg::PLEN-1:0]      pptr_i,
    // pmpaddr of this entry
    input  logic [ptw_pkg::PMP_ADDRW-1:0] addr_i,
    // pmpaddr of the entry below, zero for entry 0
    input  logic [ptw_pkg::PMP_ADDRW-1:0] prev_addr_i,
    // A field of this entry's config byte
    input  logic [1:0]                    mode_i,
    output logic                          match_o
);
    import ptw_pkg::*;

    // word address, same granularity as pmpaddr
    logic [PMP_ADDRW-1:0] word_addr;
    // napot care mask, zero over the region offset bits
    logic [PMP_ADDRW-1:0] napot_mask;
    logic                 tor_hit;
    logic                 napot_hit;

    assign word_addr = pptr_i[PLEN-1:2];

    // ----------------------------------------
    // top of range
    // ----------------------------------------

    // region is [prev_addr, addr), both in words
    assign tor_hit = (word_addr >= prev_addr_i) && (word_addr < addr_i);

    // ----------------------------------------
    // naturally aligned power of two
    // ----------------------------------------

    // addr ^ (addr + 1) sets the t trailing ones plus the zero above them,
    // so the inverse keeps only the base bits of a 2^(t+3) byte region
    // t = 0 gives the 8 byte minimum, all ones gives the whole space
    assign napot_mask = ~(addr_i ^ (addr_i + 1'b1));
    assign napot_hit  = ((word_addr & napot_mask) == (addr_i & napot_mask));

    // mode select
    always_comb begin
        case (mode_i)
            PMP_OFF:   match_o = 1'b0;
            PMP_TOR:   match_o = tor_hit;
            PMP_NAPOT: match_o = napot_hit;
            // na4 is not supported
            default:   match_o = 1'b0;
        endcase
    end

endmodule

// ==== hdl/pmp_priority_select.sv ====
module pmp_priority_select (
    // one match bit per pmp entry
    input  logic [ptw_pkg::PMP_ENTRIES-1:0]      match_i,
    // config byte per entry
    input  logic [ptw_pkg::PMP_ENTRIES-1:0][7:0] cfg_i,
    // read permission of the winning entry
    output logic                                 allow_o
);
    import ptw_pkg::*;

    // ----------------------------------------
    // static priority
    // ----------------------------------------

    // walker reads are S-mode loads, only the R bit matters
    // lock bit is ignored since it never applies below M-mode here
    always_comb begin
        // no matching entry means deny for S-mode
        allow_o = 1'b0;
        // scan from the top down so the lowest index is written last
        // and therefore wins
        for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
            if (match_i[i]) begin
                allow_o = cfg_i[i][PMP_R];
            end
        end
    end

endmodule

// ==== hdl/ptw_walk_fsm.sv ====
module ptw_walk_fsm (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // abort the current walk
    input  logic                      flush_i,
    // miss request from the TLB
    input  logic                      tlb_miss_valid_i,
    input  logic [ptw_pkg::VLEN-1:0]  miss_vaddr_i,
    input  logic                      miss_is_instr_i,
    input  logic                      miss_is_store_i,
    input  logic [ptw_pkg::ASIDW-1:0] asid_i,
    // csr state
    input  logic [ptw_pkg::PPNW-1:0]  satp_ppn_i,
    input  logic                      mxr_i,
    // page-table memory port
    output logic                      mem_req_o,
    output logic [ptw_pkg::PLEN-1:0]  mem_addr_o,
    input  logic                      mem_gnt_i,
    input  logic                      mem_rvalid_i,
    input  logic [31:0]               mem_rdata_i,
    // pmp verdict on the current pointer
    input  logic                      pmp_allow_i,
    // status and faults
    output logic                      ptw_active_o,
    output logic                      walking_instr_o,
    output logic                      ptw_error_o,
    output logic                      access_error_o,
    output logic [ptw_pkg::PLEN-1:0]  bad_paddr_o,
    output logic                      tlb_miss_o,
    // TLB update
    output logic                      update_valid_o,
    output logic [ptw_pkg::VPNW-1:0]  update_vpn_o,
    output logic                      update_is_4m_o,
    output logic [ptw_pkg::ASIDW-1:0] update_asid_o,
    output logic [31:0]               update_pte_o
);
    import ptw_pkg::*;

    enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR,
        PROPAGATE_ACCESS_ERROR,
        LATENCY
    } state_q, state_d;

    // two levels under Sv32, LVL1 is the root table
    enum logic {
        LVL1,
        LVL2
    } lvl_q, lvl_d;

    // control flags of the walk
    logic is_instr_q, is_instr_d;
    logic is_store_q, is_store_d;
    logic global_q, global_d;
    logic rvalid_q;

    // payload of the walk
    logic [ASIDW-1:0] asid_q, asid_d;
    logic [VLEN-1:0]  vaddr_q, vaddr_d;
    // word aligned pointer to the PTE being read
    logic [PLEN-1:0]  pptr_q, pptr_d;
    // registered read data
    logic [31:0]      pte_q;

    // decode of pte_q
    logic pte_invalid;
    logic pte_leaf;
    logic leaf_ok;
    logic misaligned;

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign mem_req_o       = (state_q == WAIT_GRANT);
    assign mem_addr_o      = pptr_q;
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;
    // faulting address only while the access fault is shown
    assign bad_paddr_o     = access_error_o ? pptr_q : '0;

    assign update_vpn_o   = vaddr_q[VLEN-1:12];
    assign update_is_4m_o = (lvl_q == LVL1);
    assign update_asid_o  = asid_q;
    // G from any earlier level is folded into the stored leaf
    assign update_pte_o   = pte_q | (32'(global_q) << PTE_G);

    // ----------------------------------------
    // PTE rule checks
    // ----------------------------------------

    // not valid, or write without read
    assign pte_invalid = !pte_q[PTE_V] || (!pte_q[PTE_R] && pte_q[PTE_W]);
    // R or X marks a leaf, otherwise a pointer
    assign pte_leaf    = pte_q[PTE_R] || pte_q[PTE_X];
    // 4M leaf needs ppn[0] clear
    assign misaligned  = (lvl_q == LVL1) && (pte_q[19:10] != '0);

    always_comb begin
        if (is_instr_q) begin
            // fetch needs execute and accessed
            leaf_ok = pte_q[PTE_X] && pte_q[PTE_A];
        end else begin
            // loads read R, or X when mxr is set
            leaf_ok = pte_q[PTE_A] && (pte_q[PTE_R] || (pte_q[PTE_X] && mxr_i));
            // stores also need W and a dirty page
            if (is_store_q && (!pte_q[PTE_W] || !pte_q[PTE_D])) begin
                leaf_ok = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // walk FSM
    // ----------------------------------------

    always_comb begin
        state_d        = state_q;
        lvl_d          = lvl_q;
        is_instr_d     = is_instr_q;
        is_store_d     = is_store_q;
        global_d       = global_q;
        asid_d         = asid_q;
        vaddr_d        = vaddr_q;
        pptr_d         = pptr_q;
        ptw_error_o    = 1'b0;
        access_error_o = 1'b0;
        update_valid_o = 1'b0;
        tlb_miss_o     = 1'b0;

        case (state_q)
            IDLE: begin
                lvl_d      = LVL1;
                global_d   = 1'b0;
                is_instr_d = 1'b0;
                if (tlb_miss_valid_i) begin
                    // root pointer is satp.ppn * 4K + vpn[1] * 4
                    pptr_d     = {satp_ppn_i, miss_vaddr_i[VLEN-1:22], 2'b00};
                    vaddr_d    = miss_vaddr_i;
                    asid_d     = asid_i;
                    is_instr_d = miss_is_instr_i;
                    is_store_d = miss_is_store_i;
                    tlb_miss_o = 1'b1;
                    state_d    = WAIT_GRANT;
                end
            end

            // request held until granted
            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    if (pte_q[PTE_G]) begin
                        global_d = 1'b1;
                    end
                    if (pte_invalid) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (pte_leaf) begin
                        if (leaf_ok && !misaligned) begin
                            update_valid_o = 1'b1;
                            state_d        = LATENCY;
                        end else begin
                            state_d = PROPAGATE_ERROR;
                        end
                    end else if (lvl_q == LVL1) begin
                        // pointer, next table at pte.ppn * 4K + vpn[0] * 4
                        lvl_d   = LVL2;
                        pptr_d  = {pte_q[31:10], vaddr_q[21:12], 2'b00};
                        state_d = WAIT_GRANT;
                    end else begin
                        // pointer at the last level
                        state_d = PROPAGATE_ERROR;
                    end
                    // pmp deny beats every other outcome
                    if (!pmp_allow_i) begin
                        update_valid_o = 1'b0;
                        pptr_d         = pptr_q;
                        state_d        = PROPAGATE_ACCESS_ERROR;
                    end
                end
            end

            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = LATENCY;
            end

            PROPAGATE_ACCESS_ERROR: begin
                access_error_o = 1'b1;
                state_d        = LATENCY;
            end

            // drain the response owed after a flush
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end

            LATENCY: state_d = IDLE;

            default: state_d = IDLE;
        endcase

        // flush, but never leave a read response behind
        if (flush_i) begin
            if (((state_q inside {PTE_LOOKUP, WAIT_RVALID}) && !rvalid_q) ||
                ((state_q == WAIT_GRANT) && mem_gnt_i)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = LATENCY;
            end
        end
    end

    // ----------------------------------------
    // registers
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            is_store_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            is_store_q <= is_store_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        asid_q  <= asid_d;
        vaddr_q <= vaddr_d;
        pptr_q  <= pptr_d;
        // sample read data with its valid
        if (mem_rvalid_i) begin
            pte_q <= mem_rdata_i;
        end
    end

endmodule

// ==== hdl/sv32_ptw.sv ====
module sv32_ptw (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  logic                                            flush_i,
    // miss request
    input  logic                                            tlb_miss_valid_i,
    input  logic [ptw_pkg::VLEN-1:0]                        miss_vaddr_i,
    input  logic                                            miss_is_instr_i,
    input  logic                                            miss_is_store_i,
    input  logic [ptw_pkg::ASIDW-1:0]                       asid_i,
    // csr state
    input  logic [ptw_pkg::PPNW-1:0]                        satp_ppn_i,
    input  logic                                            mxr_i,
    input  logic [ptw_pkg::PMP_ENTRIES-1:0][7:0]            pmpcfg_i,
    input  logic [ptw_pkg::PMP_ENTRIES-1:0][ptw_pkg::PMP_ADDRW-1:0] pmpaddr_i,
    // page-table memory port
    output logic                                            mem_req_o,
    output logic [ptw_pkg::PLEN-1:0]                        mem_addr_o,
    input  logic                                            mem_gnt_i,
    input  logic                                            mem_rvalid_i,
    input  logic [31:0]                                     mem_rdata_i,
    // status and faults
    output logic                                            ptw_active_o,
    output logic                                            walking_instr_o,
    output logic                                            ptw_error_o,
    output logic                                            access_error_o,
    output logic [ptw_pkg::PLEN-1:0]                        bad_paddr_o,
    output logic                                            tlb_miss_o,
    // TLB update
    output logic                                            update_valid_o,
    output logic [ptw_pkg::VPNW-1:0]                        update_vpn_o,
    output logic                                            update_is_4m_o,
    output logic [ptw_pkg::ASIDW-1:0]                       update_asid_o,
    output logic [31:0]                                     update_pte_o
);
    import ptw_pkg::*;

    logic [PMP_ENTRIES-1:0]                pmp_match;
    logic [PMP_ENTRIES-1:0][PMP_ADDRW-1:0] pmp_prev_addr;
    logic                                  pmp_allow;

    ptw_walk_fsm u_walk (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .tlb_miss_valid_i (tlb_miss_valid_i),
        .miss_vaddr_i     (miss_vaddr_i),
        .miss_is_instr_i  (miss_is_instr_i),
        .miss_is_store_i  (miss_is_store_i),
        .asid_i           (asid_i),
        .satp_ppn_i       (satp_ppn_i),
        .mxr_i            (mxr_i),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_gnt_i        (mem_gnt_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .pmp_allow_i      (pmp_allow),
        .ptw_active_o     (ptw_active_o),
        .walking_instr_o  (walking_instr_o),
        .ptw_error_o      (ptw_error_o),
        .access_error_o   (access_error_o),
        .bad_paddr_o      (bad_paddr_o),
        .tlb_miss_o       (tlb_miss_o),
        .update_valid_o   (update_valid_o),
        .update_vpn_o     (update_vpn_o),
        .update_is_4m_o   (update_is_4m_o),
        .update_asid_o    (update_asid_o),
        .update_pte_o     (update_pte_o)
    );

    // ----------------------------------------
    // pmp matchers, one per entry
    // ----------------------------------------

    for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_pmp
        // tor lower bound comes from the entry below
        if (i == 0) begin : g_first
            assign pmp_prev_addr[i] = '0;
        end else begin : g_rest
            assign pmp_prev_addr[i] = pmpaddr_i[i-1];
        end

        // the pointer register is checked as it goes out on the bus
        pmp_region_match u_match (
            .pptr_i      (mem_addr_o),
            .addr_i      (pmpaddr_i[i]),
            .prev_addr_i (pmp_prev_addr[i]),
            .mode_i      (pmpcfg_i[i][PMP_A_LSB +: 2]),
            .match_o     (pmp_match[i])
        );
    end

    pmp_priority_select u_select (
        .match_i (pmp_match),
        .cfg_i   (pmpcfg_i),
        .allow_o (pmp_allow)
    );

endmodule

// ==== dv/ptw_mem_model.sv ====
module ptw_mem_model (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // request side, driven by the walker
    input  logic                     req_i,
    input  logic [ptw_pkg::PLEN-1:0] addr_i,
    output logic                     gnt_o,
    // response side
    output logic                     rvalid_o,
    output logic [31:0]              rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import ptw_pkg::*;

    // page-table words keyed by word address, pptr bits 33:2
    logic [31:0] mem [logic [31:0]];
    // 16 bit galois lfsr behind the grant delay
    logic [15:0] lfsr_q;
    logic [15:0] lfsr_s1;
    // cycles left before the pending request is granted
    logic [1:0]  delay_q;

    // shift right, fold the taps back in when a one drops out
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // unwritten words read as invalid PTEs that differ per address
    function automatic logic [31:0] fill_word(input logic [31:0] waddr);
        return (waddr * 32'h9E37_79B1) & ~32'h1;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] waddr);
        if (mem.exists(waddr)) begin
            return mem[waddr];
        end
        return fill_word(waddr);
    endfunction

    task automatic store_word(input logic [31:0] waddr, input logic [31:0] data);
        mem[waddr] = data;
    endtask

    // grant as soon as the drawn delay has run out
    assign gnt_o   = req_i && (delay_q == 2'd0);
    assign lfsr_s1 = lfsr_step(lfsr_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q   <= 16'd82;
            delay_q  <= 2'd0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            // one read-valid, one cycle after each grant
            rvalid_o <= gnt_o;
            if (gnt_o) begin
                rdata_o <= read_word(addr_i[PLEN-1:2]);
                // two fresh bits, one lfsr step each, for the next request
                delay_q <= {lfsr_s1[0], lfsr_q[0]};
                lfsr_q  <= lfsr_step(lfsr_s1);
            end else if (req_i && (delay_q != 2'd0)) begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

endmodule

// ==== dv/sv32_ptw_tb.sv ====
module sv32_ptw_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ptw_pkg::*;

    // walk result, one hot as {access fault, page fault, update}
    localparam logic [2:0] K_NONE  = 3'b000;
    localparam logic [2:0] K_UPD   = 3'b001;
    localparam logic [2:0] K_PF    = 3'b010;
    localparam logic [2:0] K_AF    = 3'b100;
    localparam int         TIMEOUT = 60;

    // PTE flag masks
    localparam logic [9:0] F_V = 10'd1 << PTE_V;
    localparam logic [9:0] F_R = 10'd1 << PTE_R;
    localparam logic [9:0] F_W = 10'd1 << PTE_W;
    localparam logic [9:0] F_X = 10'd1 << PTE_X;
    localparam logic [9:0] F_G = 10'd1 << PTE_G;
    localparam logic [9:0] F_A = 10'd1 << PTE_A;
    localparam logic [9:0] F_D = 10'd1 << PTE_D;

    // root table and two second level tables
    localparam logic [21:0] ROOT  = 22'h00010;
    localparam logic [21:0] TBL_A = 22'h00020;
    localparam logic [21:0] TBL_B = 22'h00030;

    localparam logic [7:0] CFG_NAPOT_R = (8'(PMP_NAPOT) << PMP_A_LSB) | (8'd1 << PMP_R);
    localparam logic [7:0] CFG_TOR     = 8'(PMP_TOR) << PMP_A_LSB;

    logic clk_i, rst_ni, flush_i, mxr_i;
    logic tlb_miss_valid_i, miss_is_instr_i, miss_is_store_i;
    logic [VLEN-1:0]  miss_vaddr_i;
    logic [ASIDW-1:0] asid_i, update_asid_o;
    logic [PPNW-1:0]  satp_ppn_i;
    logic [PMP_ENTRIES-1:0][7:0]           pmpcfg_i;
    logic [PMP_ENTRIES-1:0][PMP_ADDRW-1:0] pmpaddr_i;
    logic mem_req_o, mem_gnt_i, mem_rvalid_i;
    logic [PLEN-1:0]  mem_addr_o, bad_paddr_o;
    logic [31:0]      mem_rdata_i, update_pte_o;
    logic ptw_active_o, walking_instr_o, ptw_error_o, access_error_o, tlb_miss_o;
    logic update_valid_o, update_is_4m_o;
    logic [VPNW-1:0]  update_vpn_o;

    // expectations of the running walk
    string                  test_name;
    logic [2:0]             exp_kind;
    logic [VPNW+ASIDW+32:0] exp_upd;
    logic [PLEN-1:0]        exp_bad;
    logic                   exp_instr;
    // actual values in the same shape
    logic [2:0]             outcome;
    logic [VPNW+ASIDW+32:0] upd_act;
    logic [PLEN-1:0]        bad_exp_now;
    // high from an accepted miss until its result or a flush
    logic                   walk_open;
    int errors, timeouts, walk_cnt;

    assign outcome     = {access_error_o, ptw_error_o, update_valid_o};
    assign upd_act     = {update_vpn_o, update_asid_o, update_is_4m_o, update_pte_o};
    assign bad_exp_now = access_error_o ? exp_bad : '0;

    sv32_ptw DUT (.*);

    ptw_mem_model u_mem (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (mem_req_o),
        .addr_i   (mem_addr_o),
        .gnt_o    (mem_gnt_i),
        .rvalid_o (mem_rvalid_i),
        .rdata_o  (mem_rdata_i)
    );

    always #20 clk_i = ~clk_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            walk_open <= 1'b0;
        end else if ((outcome != K_NONE) || flush_i) begin
            walk_open <= 1'b0;
        end else if (tlb_miss_valid_i && !ptw_active_o) begin
            walk_open <= 1'b1;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // any result must be the one the walk expects, none at all under flush
    a_outcome: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (outcome != K_NONE) |-> (outcome == exp_kind))
        else begin
            $display("error %s expected %b actual %b", test_name, exp_kind, $sampled(outcome));
            errors++;
        end

    // vpn, asid, 4m flag and merged PTE of an update
    a_update: assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_valid_o |-> (upd_act == exp_upd))
        else begin
            $display("error %s expected %h actual %h", test_name, exp_upd, $sampled(upd_act));
            errors++;
        end

    // faulting address only alongside an access fault
    a_bad_paddr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bad_paddr_o == bad_exp_now)
        else begin
            $display("error %s expected %h actual %h", test_name, $sampled(bad_exp_now),
                     $sampled(bad_paddr_o));
            errors++;
        end

    // every miss goes to an idle walker, so each one is taken
    a_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tlb_miss_o == tlb_miss_valid_i)
        else begin
            $display("error %s expected %b actual %b", test_name, $sampled(tlb_miss_valid_i),
                     $sampled(tlb_miss_o));
            errors++;
        end

    // fetch flag of the walk while it runs
    a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        walk_open |-> (walking_instr_o == exp_instr))
        else begin
            $display("error %s expected %b actual %b", test_name, exp_instr,
                     $sampled(walking_instr_o));
            errors++;
        end

    // request and address held until granted
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i && !flush_i) |=> (mem_req_o && $stable(mem_addr_o)))
        else begin
            $display("%s: request dropped or address moved before the grant", test_name);
            errors++;
        end

    a_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
        walk_open |-> ptw_active_o)
        else begin
            $display("%s: walker went idle before the walk ended", test_name);
            errors++;
        end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [9:0] flags);
        return {ppn, flags};
    endfunction

    // page offset is arbitrary, the walker ignores it
    function automatic logic [31:0] vaddr_of(input logic [9:0] vpn1, input logic [9:0] vpn0);
        return {vpn1, vpn0, 12'h0A4};
    endfunction

    function automatic logic [PLEN-1:0] pte_addr(input logic [21:0] tbl_ppn,
                                                 input logic [9:0] idx);
        return {tbl_ppn, idx, 2'b00};
    endfunction

    task automatic put_pte(input logic [21:0] tbl_ppn, input logic [9:0] idx,
                           input logic [31:0] pte);
        u_mem.store_word({tbl_ppn, idx}, pte);
    endtask

    // one cycle miss pulse, entered and left at posedge plus 2 ns
    task automatic start_miss(input logic [31:0] va, input logic instr, input logic store);
        exp_instr        = instr;
        tlb_miss_valid_i = 1'b1;
        miss_vaddr_i     = va;
        miss_is_instr_i  = instr;
        miss_is_store_i  = store;
        asid_i           = walk_cnt[ASIDW-1:0];
        @(posedge clk_i);
        #2;
        tlb_miss_valid_i = 1'b0;
    endtask

    // outputs are sampled at the falling edge where they are settled
    task automatic wait_for(input string what);
        int n;
        bit hit;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_i);
            if (what == "result") begin
                hit = (outcome != K_NONE);
            end else if (what == "grant") begin
                hit = mem_req_o && mem_gnt_i;
            end else begin
                hit = !ptw_active_o;
            end
            if (hit) begin
                break;
            end
        end
        if (n == TIMEOUT) begin
            $display("timeout in %s while waiting for %s", test_name, what);
            timeouts++;
        end
        @(posedge clk_i);
        #2;
    endtask

    task automatic run_walk(input string name, input logic [31:0] va, input logic instr,
                            input logic store, input logic [2:0] kind,
                            input logic [31:0] pte, input logic is_4m,
                            input logic [PLEN-1:0] bad);
        walk_cnt++;
        test_name = name;
        exp_kind  = kind;
        exp_upd   = {va[31:12], walk_cnt[ASIDW-1:0], is_4m, pte};
        exp_bad   = bad;
        start_miss(va, instr, store);
        wait_for("result");
        wait_for("idle");
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        mxr_i            = 1'b0;
        tlb_miss_valid_i = 1'b0;
        miss_vaddr_i     = '0;
        miss_is_instr_i  = 1'b0;
        miss_is_store_i  = 1'b0;
        asid_i           = '0;
        satp_ppn_i       = ROOT;
        pmpcfg_i         = '0;
        pmpaddr_i        = '0;
        // all ones is the largest napot region, so entry 15 opens all memory
        pmpaddr_i[15]    = '1;
        pmpcfg_i[15]     = CFG_NAPOT_R;
        errors           = 0;
        timeouts         = 0;
        walk_cnt         = 0;
        test_name        = "reset";
        exp_kind         = K_NONE;
        exp_upd          = '0;
        exp_bad          = '0;
        exp_instr        = 1'b0;

        // root: global pointer, aligned and misaligned 4M leaves, plain pointer
        put_pte(ROOT, 10'd1, make_pte(TBL_A, F_V | F_G));
        put_pte(ROOT, 10'd2, make_pte({12'h0AB, 10'h000}, F_V | F_R | F_A));
        put_pte(ROOT, 10'd3, make_pte({12'h0AB, 10'h004}, F_V | F_R | F_A));
        put_pte(ROOT, 10'd5, make_pte(TBL_B, F_V));
        // second level leaves, each missing one permission
        put_pte(TBL_A, 10'd5, make_pte(22'h12345, F_V | F_R | F_W | F_A | F_D));
        put_pte(TBL_A, 10'd6, make_pte(TBL_A, F_V));
        put_pte(TBL_A, 10'd7, make_pte(22'h00111, F_V | F_R | F_A | F_D));
        put_pte(TBL_A, 10'd8, make_pte(22'h00112, F_V | F_R | F_W | F_A));
        put_pte(TBL_A, 10'd9, make_pte(22'h00113, F_V | F_R | F_W | F_A | F_D));
        put_pte(TBL_A, 10'd10, make_pte(22'h00114, F_V | F_R | F_W | F_D));
        put_pte(TBL_A, 10'd11, make_pte(22'h00115, F_V | F_X | F_A));
        put_pte(TBL_B, 10'd3, make_pte(22'h00116, F_V | F_R | F_A));

        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // G of the root pointer shows up in the stored leaf
        run_walk("walk_4k", vaddr_of(10'd1, 10'd5), 1'b0, 1'b0, K_UPD,
                 make_pte(22'h12345, F_V | F_R | F_W | F_A | F_D | F_G), 1'b0, '0);
        run_walk("super_4m", vaddr_of(10'd2, 10'd7), 1'b0, 1'b0, K_UPD,
                 make_pte({12'h0AB, 10'h000}, F_V | F_R | F_A), 1'b1, '0);
        run_walk("super_misaligned", vaddr_of(10'd3, 10'd0), 1'b0, 1'b0, K_PF, '0, 1'b0, '0);
        run_walk("ptr_at_level2", vaddr_of(10'd1, 10'd6), 1'b0, 1'b0, K_PF, '0, 1'b0, '0);
        run_walk("store_no_w", vaddr_of(10'd1, 10'd7), 1'b0, 1'b1, K_PF, '0, 1'b0, '0);
        run_walk("store_no_d", vaddr_of(10'd1, 10'd8), 1'b0, 1'b1, K_PF, '0, 1'b0, '0);
        run_walk("fetch_no_x", vaddr_of(10'd1, 10'd9), 1'b1, 1'b0, K_PF, '0, 1'b0, '0);
        run_walk("load_no_a", vaddr_of(10'd1, 10'd10), 1'b0, 1'b0, K_PF, '0, 1'b0, '0);
        run_walk("xonly_no_mxr", vaddr_of(10'd1, 10'd11), 1'b0, 1'b0, K_PF, '0, 1'b0, '0);
        mxr_i = 1'b1;
        run_walk("xonly_mxr", vaddr_of(10'd1, 10'd11), 1'b0, 1'b0, K_UPD,
                 make_pte(22'h00115, F_V | F_X | F_A | F_G), 1'b0, '0);
        mxr_i = 1'b0;

        // flush once the first read is granted, its data still owed
        walk_cnt++;
        test_name = "flush";
        exp_kind  = K_NONE;
        start_miss(vaddr_of(10'd1, 10'd5), 1'b0, 1'b0);
        wait_for("grant");
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        wait_for("idle");
        run_walk("after_flush", vaddr_of(10'd1, 10'd5), 1'b0, 1'b0, K_UPD,
                 make_pte(22'h12345, F_V | F_R | F_W | F_A | F_D | F_G), 1'b0, '0);

        // tor entry 1 without R over the whole of table B
        pmpaddr_i[0] = {TBL_B, 10'h000};
        pmpaddr_i[1] = {TBL_B + 22'd1, 10'h000};
        pmpcfg_i[1]  = CFG_TOR;
        run_walk("pmp_tor_deny", vaddr_of(10'd5, 10'd3), 1'b0, 1'b0, K_AF, '0, 1'b0,
                 pte_addr(TBL_B, 10'd3));
        // shrink entry 15 to a 4 KiB page at 0x40000, away from every table
        pmpaddr_i[15] = 32'h0001_01FF;
        run_walk("pmp_no_region", vaddr_of(10'd1, 10'd5), 1'b0, 1'b0, K_AF, '0, 1'b0,
                 pte_addr(ROOT, 10'd1));

        repeat (2) @(posedge clk_i);
        $display("walks: %0d, assertion errors: %0d, timeouts: %0d", walk_cnt, errors,
                 timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sv32_ptw.f ====
hdl/ptw_pkg.sv
hdl/pmp_region_match.sv
hdl/pmp_priority_select.sv
hdl/ptw_walk_fsm.sv
hdl/sv32_ptw.sv
dv/ptw_mem_model.sv
dv/sv32_ptw_tb.sv

// ==== Bender.yml ====
package:
  name: sv32_ptw

sources:
  - hdl/ptw_pkg.sv
  - hdl/pmp_region_match.sv
  - hdl/pmp_priority_select.sv
  - hdl/ptw_walk_fsm.sv
  - hdl/sv32_ptw.sv
  - target: test
    files:
      - dv/ptw_mem_model.sv
      - dv/sv32_ptw_tb.sv
